//--- rtl/rows_serial_settings.svh
`ifndef ROWS_SERIAL_SETTINGS_SVH
`define ROWS_SERIAL_SETTINGS_SVH

// Bits per pixel
`define ROWS_DATA_WIDTH 8

// Pixels per row, one line buffer holds exactly one row
`define ROWS_ROW_WIDTH  16
`define ROWS_ADDR_WIDTH 4

// Rows carried by one input beat
`define ROWS_LANES      3

// Idle cycles between output rows
`define ROWS_LINE_GAP   4

`endif

//--- rtl/video_pkg.sv
`default_nettype none

`include "rows_serial_settings.svh"

package video_pkg;

    typedef logic [`ROWS_DATA_WIDTH-1:0] pixel_t;

    // Lane 0 sits at index 0
    typedef pixel_t [`ROWS_LANES-1:0] lanes_t;

    // One serial video beat
    typedef struct packed {
        logic   h_sync;
        logic   v_sync;
        pixel_t pixel;
    } video_beat_t;

endpackage

`default_nettype wire

//--- rtl/buffer_pkg.sv
`default_nettype none

`include "rows_serial_settings.svh"

package buffer_pkg;

    typedef struct packed {
        logic                        en;
        logic [`ROWS_ADDR_WIDTH-1:0] addr;
        video_pkg::pixel_t           data;
    } buf_wr_t;

    // Shared by all buffered lanes
    typedef struct packed {
        logic                        en;
        logic [`ROWS_ADDR_WIDTH-1:0] addr;
    } buf_rd_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DIRECT,
        S_GAP,
        S_REPLAY
    } serial_state_e;

endpackage

`default_nettype wire

//--- rtl/row_splitter.sv
`timescale 1ns/100ps
`default_nettype none

`include "rows_serial_settings.svh"

module row_splitter (
    input  wire                                   i_clk,
    input  wire                                   i_rst_n,
    input  wire                                   i_h_sync,
    input  wire                                   i_v_sync,
    input  wire video_pkg::lanes_t                i_data,
    output video_pkg::video_beat_t                o_direct,
    output buffer_pkg::buf_wr_t [`ROWS_LANES-2:0] o_wr
);

    logic                        line_valid;
    logic [`ROWS_ADDR_WIDTH-1:0] col;

    // h_sync only counts inside a frame
    assign line_valid = i_h_sync && i_v_sync;

    //////////////////////////////////////////////////
    // Column counter, doubles as write address
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col <= '0;
        end else if (line_valid) begin
            col <= col + 1'b1;
        end else begin
            col <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Lane 0 direct, other lanes to line buffers
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_direct <= '0;
        end else begin
            o_direct.h_sync <= line_valid;
            o_direct.v_sync <= i_v_sync;
            o_direct.pixel  <= i_data[0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr <= '0;
        end else begin
            for (int k = 0; k < `ROWS_LANES - 1; k++) begin
                o_wr[k].en   <= line_valid;
                o_wr[k].addr <= col;
                // Buffer k holds lane k+1
                o_wr[k].data <= i_data[k+1];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "rows_serial_settings.svh"

module line_buffer (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire buffer_pkg::buf_wr_t i_wr,
    input  wire buffer_pkg::buf_rd_t i_rd,
    output video_pkg::pixel_t        o_rd_pixel
);

    localparam int LAST_COL_I = `ROWS_ROW_WIDTH - 1;
    localparam logic [`ROWS_ADDR_WIDTH-1:0] LAST_COL = LAST_COL_I[`ROWS_ADDR_WIDTH-1:0];

    video_pkg::pixel_t mem [`ROWS_ROW_WIDTH];
    logic              full;

    // One row of storage, registered read
    always_ff @(posedge i_clk) begin
        if (i_wr.en) begin
            mem[i_wr.addr] <= i_wr.data;
        end
        if (i_rd.en) begin
            o_rd_pixel <= mem[i_rd.addr];
        end
    end

    // Full from last column written until last column read
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            full <= 1'b0;
        end else if (i_wr.en && i_wr.addr == LAST_COL) begin
            full <= 1'b1;
        end else if (i_rd.en && i_rd.addr == LAST_COL) begin
            full <= 1'b0;
        end
    end

    // Next input row must not land before the stored row was replayed
    a_no_write_when_full: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_wr.en |-> !full
    );

endmodule

`default_nettype wire

//--- rtl/row_serializer.sv
`timescale 1ns/100ps
`default_nettype none

`include "rows_serial_settings.svh"

module row_serializer (
    input  wire                                   i_clk,
    input  wire                                   i_rst_n,
    input  wire video_pkg::video_beat_t           i_direct,
    input  wire video_pkg::pixel_t [`ROWS_LANES-2:0] i_rd_pixel,
    output buffer_pkg::buf_rd_t                   o_rd,
    output logic                                  o_h_sync,
    output logic                                  o_v_sync,
    output video_pkg::pixel_t                     o_data
);

    localparam int AW         = `ROWS_ADDR_WIDTH;
    localparam int GAP_W      = $clog2(`ROWS_LINE_GAP + 1);
    localparam int SEL_W      = $clog2(`ROWS_LANES - 1);
    localparam int LAST_COL_I = `ROWS_ROW_WIDTH - 1;
    localparam int GAP_LAST_I = `ROWS_LINE_GAP - 1;
    localparam int LAST_SEL_I = `ROWS_LANES - 2;
    // After a direct row, the detect cycle and the read latency eat into the gap
    localparam int GAP_SKIP_I = 2;

    localparam logic [AW-1:0]    LAST_COL = LAST_COL_I[AW-1:0];
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_LAST_I[GAP_W-1:0];
    localparam logic [GAP_W-1:0] GAP_SKIP = GAP_SKIP_I[GAP_W-1:0];
    localparam logic [SEL_W-1:0] LAST_SEL = LAST_SEL_I[SEL_W-1:0];

    buffer_pkg::serial_state_e state;
    logic [AW-1:0]             col;
    logic [GAP_W-1:0]          gap_cnt;
    logic [SEL_W-1:0]          buf_sel;
    logic                      rd_valid;
    logic [SEL_W-1:0]          rd_sel;

    //////////////////////////////////////////////////
    // Row sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= buffer_pkg::S_IDLE;
            col     <= '0;
            gap_cnt <= '0;
            buf_sel <= '0;
        end else if (!i_direct.v_sync) begin
            state   <= buffer_pkg::S_IDLE;
            col     <= '0;
            gap_cnt <= '0;
            buf_sel <= '0;
        end else begin
            case (state)
                buffer_pkg::S_IDLE: begin
                    if (i_direct.h_sync) begin
                        state <= buffer_pkg::S_DIRECT;
                    end
                end
                buffer_pkg::S_DIRECT: begin
                    if (!i_direct.h_sync) begin
                        state   <= buffer_pkg::S_GAP;
                        gap_cnt <= GAP_SKIP;
                        buf_sel <= '0;
                    end
                end
                buffer_pkg::S_GAP: begin
                    if (gap_cnt == GAP_LAST) begin
                        state <= buffer_pkg::S_REPLAY;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                buffer_pkg::S_REPLAY: begin
                    col <= col + 1'b1;
                    if (col == LAST_COL) begin
                        col <= '0;
                        if (buf_sel == LAST_SEL) begin
                            state <= buffer_pkg::S_IDLE;
                        end else begin
                            state   <= buffer_pkg::S_GAP;
                            gap_cnt <= '0;
                            buf_sel <= buf_sel + 1'b1;
                        end
                    end
                end
                default: state <= buffer_pkg::S_IDLE;
            endcase
        end
    end

    // Read one cycle ahead of the output register
    always_comb begin
        o_rd.en   = (state == buffer_pkg::S_REPLAY);
        o_rd.addr = col;
    end

    //////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_valid <= 1'b0;
            rd_sel   <= '0;
            o_h_sync <= 1'b0;
            o_v_sync <= 1'b0;
            o_data   <= '0;
        end else begin
            rd_valid <= o_rd.en;
            rd_sel   <= buf_sel;
            o_v_sync <= i_direct.v_sync;
            if (i_direct.h_sync) begin
                o_h_sync <= 1'b1;
                o_data   <= i_direct.pixel;
            end else if (rd_valid) begin
                o_h_sync <= 1'b1;
                o_data   <= i_rd_pixel[rd_sel];
            end else begin
                o_h_sync <= 1'b0;
                o_data   <= '0;
            end
        end
    end

    // Input row spacing keeps direct rows clear of the replays
    a_direct_from_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_direct.h_sync) |-> state == buffer_pkg::S_IDLE
    );

endmodule

`default_nettype wire

//--- rtl/parallel_rows_to_serial.sv
`timescale 1ns/100ps
`default_nettype none

`include "rows_serial_settings.svh"

module parallel_rows_to_serial (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_h_sync,
    input  wire                    i_v_sync,
    input  wire video_pkg::lanes_t i_data,
    output logic                   o_h_sync,
    output logic                   o_v_sync,
    output video_pkg::pixel_t      o_data
);

    video_pkg::video_beat_t                   direct;
    buffer_pkg::buf_wr_t [`ROWS_LANES-2:0]    wr;
    buffer_pkg::buf_rd_t                      rd;
    video_pkg::pixel_t [`ROWS_LANES-2:0]      rd_pixel;

    row_splitter u_splitter (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_h_sync (i_h_sync),
        .i_v_sync (i_v_sync),
        .i_data   (i_data),
        .o_direct (direct),
        .o_wr     (wr)
    );

    // One line buffer per replayed lane
    for (genvar g = 0; g < `ROWS_LANES - 1; g++) begin : g_buf
        line_buffer u_buf (
            .i_clk      (i_clk),
            .i_rst_n    (i_rst_n),
            .i_wr       (wr[g]),
            .i_rd       (rd),
            .o_rd_pixel (rd_pixel[g])
        );
    end

    row_serializer u_serializer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_direct   (direct),
        .i_rd_pixel (rd_pixel),
        .o_rd       (rd),
        .o_h_sync   (o_h_sync),
        .o_v_sync   (o_v_sync),
        .o_data     (o_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_parallel_rows_to_serial.sv
`timescale 1ns/100ps
`default_nettype none

`include "rows_serial_settings.svh"

module tb_parallel_rows_to_serial;

    localparam int W           = `ROWS_ROW_WIDTH;
    localparam int GAP         = `ROWS_LINE_GAP;
    localparam int MIN_SPACING = 3 * W + 2 * GAP + 4;
    localparam int MAX_ROWS    = 32;

    // One expected output row
    typedef struct packed {
        int row_idx;
        int lane;
        int start_cycle;
    } row_exp_t;

    logic              clk;
    logic              rst_n;
    logic              h_sync;
    logic              v_sync;
    video_pkg::lanes_t data;
    logic              o_h_sync;
    logic              o_v_sync;
    video_pkg::pixel_t o_data;

    string             row_name   [MAX_ROWS];
    video_pkg::pixel_t lane_start [MAX_ROWS][`ROWS_LANES];
    int                row_idle   [MAX_ROWS];
    int                row_errs   [MAX_ROWS];
    bit                row_done   [MAX_ROWS];
    int                num_rows;
    row_exp_t          exp_rows   [$];

    int       cyc = 0;
    int       misc_errs = 0;
    int       quiet_errs = 0;
    bit       quiet_phase = 1'b0;
    bit       wd_armed = 1'b0;
    int       limit_cycles = 0;
    logic     prev_h = 1'b0;
    bit       row_active = 1'b0;
    int       col_cnt = 0;
    row_exp_t cur_row;
    logic     v_hist1 = 1'b0;
    logic     v_hist2 = 1'b0;

    parallel_rows_to_serial DUT (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_h_sync (h_sync),
        .i_v_sync (v_sync),
        .i_data   (data),
        .o_h_sync (o_h_sync),
        .o_v_sync (o_v_sync),
        .o_data   (o_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Pixel c of a lane is its start value plus c
    function automatic video_pkg::pixel_t lane_pixel(input int idx, input int lane, input int col);
        return video_pkg::pixel_t'(int'(lane_start[idx][lane]) + col);
    endfunction

    task automatic load_stimulus(output bit ok);
        int                fd;
        int                code;
        int                ch;
        string             tok;
        video_pkg::pixel_t s0;
        video_pkg::pixel_t s1;
        video_pkg::pixel_t s2;
        int                idle;
        ok = 1'b0;
        num_rows = 0;
        fd = $fopen("testbench/rows_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/rows_stimulus.txt");
        end else begin
            ok = 1'b1;
            while (ok && $fscanf(fd, "%s", tok) == 1) begin
                if (tok.getc(0) == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%h %h %h %d", s0, s1, s2, idle);
                    if (code != 4 || num_rows == MAX_ROWS) begin
                        $display("Stimulus line for %0s is malformed or over the row limit", tok);
                        ok = 1'b0;
                    end else begin
                        row_name[num_rows]      = tok;
                        lane_start[num_rows][0] = s0;
                        lane_start[num_rows][1] = s1;
                        lane_start[num_rows][2] = s2;
                        row_idle[num_rows]      = idle;
                        num_rows++;
                    end
                end
            end
            $fclose(fd);
            if (num_rows == 0) begin
                $display("Stimulus file holds no rows");
                ok = 1'b0;
            end
        end
    endtask

    task automatic send_row(input int idx, input int spacing);
        row_exp_t e;
        @(posedge clk);
        #1;
        // Three output rows, each one row plus gap after the previous
        for (int lane = 0; lane < `ROWS_LANES; lane++) begin
            e.row_idx     = idx;
            e.lane        = lane;
            e.start_cycle = cyc + 2 + lane * (W + GAP);
            exp_rows.push_back(e);
        end
        for (int col = 0; col < W; col++) begin
            if (col != 0) begin
                @(posedge clk);
                #1;
            end
            h_sync = 1'b1;
            for (int lane = 0; lane < `ROWS_LANES; lane++) begin
                data[lane] = lane_pixel(idx, lane, col);
            end
        end
        @(posedge clk);
        #1;
        h_sync = 1'b0;
        data   = '0;
        repeat (spacing - W - 1) @(posedge clk);
    endtask

    task automatic finish_run();
        int passed;
        int failed;
        passed = (quiet_errs == 0) ? 1 : 0;
        if (exp_rows.size() != 0) begin
            $display("%0d expected output rows never appeared", exp_rows.size());
            misc_errs++;
        end
        for (int i = 0; i < num_rows; i++) begin
            if (!row_done[i]) begin
                $display("test %0s: did not complete", row_name[i]);
            end else if (row_errs[i] == 0) begin
                passed++;
            end
        end
        failed = num_rows + 1 - passed;
        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 num_rows + 1, passed, failed, misc_errs);
        if (failed == 0 && misc_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Output checker, samples at the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            assert (o_v_sync == v_hist2) else begin
                $display("FAILED v_sync_delay at cycle %0d: expected %0b, actual %0b",
                         cyc, v_hist2, o_v_sync);
                misc_errs++;
            end
            if (quiet_phase) begin
                assert (!o_h_sync && !o_v_sync && o_data == '0) else begin
                    $display("FAILED after_reset at cycle %0d: expected 0/0/00, actual %0b/%0b/%02h",
                             cyc, o_h_sync, o_v_sync, o_data);
                    quiet_errs++;
                end
            end
            if (o_h_sync && !prev_h) begin
                assert (exp_rows.size() != 0) else begin
                    $display("Output row started at cycle %0d with no row expected", cyc);
                    misc_errs++;
                end
                if (exp_rows.size() != 0) begin
                    cur_row    = exp_rows.pop_front();
                    row_active = 1'b1;
                    col_cnt    = 0;
                    assert (cyc == cur_row.start_cycle) else begin
                        $display("FAILED %0s lane %0d start cycle: expected %0d, actual %0d",
                                 row_name[cur_row.row_idx], cur_row.lane,
                                 cur_row.start_cycle, cyc);
                        row_errs[cur_row.row_idx]++;
                    end
                end
            end
            if (o_h_sync && row_active) begin
                assert (o_data == lane_pixel(cur_row.row_idx, cur_row.lane, col_cnt)) else begin
                    $display("FAILED %0s lane %0d pixel %0d: expected %02h, actual %02h",
                             row_name[cur_row.row_idx], cur_row.lane, col_cnt,
                             lane_pixel(cur_row.row_idx, cur_row.lane, col_cnt), o_data);
                    row_errs[cur_row.row_idx]++;
                end
                col_cnt++;
            end
            if (!o_h_sync && prev_h && row_active) begin
                assert (col_cnt == W) else begin
                    $display("FAILED %0s lane %0d row length: expected %0d, actual %0d",
                             row_name[cur_row.row_idx], cur_row.lane, W, col_cnt);
                    row_errs[cur_row.row_idx]++;
                end
                row_active = 1'b0;
                if (cur_row.lane == `ROWS_LANES - 1) begin
                    row_done[cur_row.row_idx] = 1'b1;
                    if (row_errs[cur_row.row_idx] == 0) begin
                        $display("test %0s: passed", row_name[cur_row.row_idx]);
                    end else begin
                        $display("test %0s: failed with %0d errors",
                                 row_name[cur_row.row_idx], row_errs[cur_row.row_idx]);
                    end
                end
            end
            prev_h = o_h_sync;
        end
        v_hist2 = v_hist1;
        v_hist1 = v_sync;
    end

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////

    initial begin
        wait (wd_armed);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        bit ok;
        clk    = 1'b0;
        rst_n  = 1'b0;
        h_sync = 1'b0;
        v_sync = 1'b0;
        data   = '0;
        void'($urandom(94865));
        load_stimulus(ok);
        if (!ok) begin
            $display("** FAIL **");
            $finish;
        end else begin
            // Worst case spacing per row plus slack
            for (int i = 0; i < num_rows; i++) begin
                limit_cycles += MIN_SPACING + row_idle[i] + 7 + 10;
            end
            limit_cycles += 100;
            wd_armed = 1'b1;
            repeat (8) @(posedge clk);
            #1;
            rst_n       = 1'b1;
            quiet_phase = 1'b1;
            repeat (6) @(posedge clk);
            #1;
            quiet_phase = 1'b0;
            if (quiet_errs == 0) begin
                $display("test after_reset: passed");
            end else begin
                $display("test after_reset: failed with %0d errors", quiet_errs);
            end
            v_sync = 1'b1;
            repeat (3) @(posedge clk);
            for (int i = 0; i < num_rows; i++) begin
                send_row(i, MIN_SPACING + row_idle[i] + int'($urandom % 8));
            end
            @(posedge clk);
            #1;
            v_sync = 1'b0;
            repeat (6) @(posedge clk);
            finish_run();
        end
    end

endmodule

`default_nettype wire

//--- parallel_rows_to_serial.f
+incdir+rtl
rtl/video_pkg.sv
rtl/buffer_pkg.sv
rtl/row_splitter.sv
rtl/line_buffer.sv
rtl/row_serializer.sv
rtl/parallel_rows_to_serial.sv
testbench/tb_parallel_rows_to_serial.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_parallel_rows_to_serial

verilator --binary --timing --assert \
    -f parallel_rows_to_serial.f \
    --top-module "$TOP" \
    --Mdir obj_dir -o sim_"$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "** PASS **" "$LOG"; then
    exit 0
fi
echo "Simulation did not report success, see $LOG"
exit 1

//--- testbench/rows_stimulus.txt
# name lane0_start lane1_start lane2_start (hex) idle_cycles (decimal)
# each lane counts up by one per pixel from its start value
ramp_zero 00 00 00 0
lanes_apart 00 40 80 0
wrap_lane0 f8 10 20 3
wrap_lane1 10 f4 30 1
wrap_lane2 20 30 f1 5
all_high ff fe fd 0
descending_starts c0 80 40 2
same_start 55 55 55 7
odd_starts 01 03 05 4
even_starts 02 04 06 0
near_wrap_all f0 f1 f2 6
mid_range 7a 7b 7c 1
alt_bits aa 55 aa 9
alt_bits_inv 55 aa 55 0
long_idle 11 22 33 12
short_idle 44 55 66 0
spread 0f 8f ef 3
top_nibble a0 b0 c0 2
low_nibble 0a 0b 0c 8
lane2_zero 99 88 00 0
lane0_zero 00 77 ee 5
final_row 3c 5a 96 1
